// File: hw/tx_dma_pkg.sv
// TX DMA lite shared definitions
// Widths, header field positions, register map and FIFO pointer types

package tx_dma_pkg;

    localparam int CHANNELS     = 4;
    localparam int PKT_SIZE_MAX = 16;
    localparam int BUF_DEPTH    = 64;
    localparam int META_DEPTH   = 8;
    localparam int BUF_AW       = $clog2(BUF_DEPTH);
    localparam int META_AW      = $clog2(META_DEPTH);

    // Vector types
    typedef logic [31:0]                       data_t;
    typedef logic [$clog2(CHANNELS)-1:0]       chan_t;
    typedef logic [$clog2(PKT_SIZE_MAX+1)-1:0] pkt_size_t;
    typedef logic [23:0]                       hdr_meta_t;
    typedef logic [15:0]                       cnt_t;
    typedef logic [31:0]                       mi_addr_t;
    typedef logic [BUF_AW:0]                   buf_ptr_t;
    typedef logic [META_AW:0]                  meta_ptr_t;

    // Request header word layout
    localparam int HDR_CHAN_MSB = 31;
    localparam int HDR_CHAN_LSB = 30;
    localparam int HDR_SIZE_MSB = 28;
    localparam int HDR_SIZE_LSB = 24;
    localparam int HDR_META_MSB = 23;
    localparam int HDR_META_LSB = 0;

    // Register map
    localparam mi_addr_t REG_CHAN_EN   = 32'h0000_0000;
    localparam mi_addr_t REG_SENT_BASE = 32'h0000_0010;
    localparam mi_addr_t REG_DROP_BASE = 32'h0000_0020;

    typedef enum logic [1:0] {
        IDLE,
        PASS,
        DROP
    } parse_state_t;

endpackage

// File: hw/tx_dma_regs.sv
// TX DMA register block on the MI port
// Holds the channel enable mask and per-channel sent and dropped counters

`timescale 1ns/1ps

module tx_dma_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  tx_dma_pkg::mi_addr_t          mi_addr,
    input  tx_dma_pkg::data_t             mi_dwr,
    input  logic                          mi_rd,
    input  logic                          mi_wr,
    output tx_dma_pkg::data_t             mi_drd,
    output logic                          mi_ardy,
    output logic                          mi_drdy,
    input  logic                          sent_pulse,
    input  tx_dma_pkg::chan_t             sent_chan,
    input  logic                          drop_pulse,
    input  tx_dma_pkg::chan_t             drop_chan,
    output logic [tx_dma_pkg::CHANNELS-1:0] chan_en
);
    import tx_dma_pkg::*;

    cnt_t  sent_cnt [CHANNELS];
    cnt_t  drop_cnt [CHANNELS];
    data_t rd_mux;
    logic  addr_aligned;
    chan_t addr_chan;

    // Requests are always taken at once
    assign mi_ardy = mi_rd | mi_wr;

    assign addr_aligned = (mi_addr[1:0] == 2'b00);
    assign addr_chan    = mi_addr[3:2];

    // Enable mask, counters are read only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chan_en <= '0;
        end else if (mi_wr && mi_addr == REG_CHAN_EN) begin
            chan_en <= mi_dwr[CHANNELS-1:0];
        end
    end

    // Wrapping packet counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < CHANNELS; c++) begin
                sent_cnt[c] <= '0;
                drop_cnt[c] <= '0;
            end
        end else begin
            if (sent_pulse) begin
                sent_cnt[sent_chan] <= sent_cnt[sent_chan] + 1'b1;
            end
            if (drop_pulse) begin
                drop_cnt[drop_chan] <= drop_cnt[drop_chan] + 1'b1;
            end
        end
    end

    // Address decode, unmapped addresses give zero
    always_comb begin
        rd_mux = '0;
        if (mi_addr == REG_CHAN_EN) begin
            rd_mux = data_t'(chan_en);
        end else if (addr_aligned && mi_addr[31:4] == REG_SENT_BASE[31:4]) begin
            rd_mux = data_t'(sent_cnt[addr_chan]);
        end else if (addr_aligned && mi_addr[31:4] == REG_DROP_BASE[31:4]) begin
            rd_mux = data_t'(drop_cnt[addr_chan]);
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mi_drdy <= 1'b0;
        end else begin
            mi_drdy <= mi_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (mi_rd) begin
            mi_drd <= rd_mux;
        end
    end

endmodule

// File: hw/tx_dma_cq_parser.sv
// PCIe request parser for the TX DMA
// Decodes the header word, filters disabled channels and forwards payload

`timescale 1ns/1ps

module tx_dma_cq_parser (
    input  logic                            clk,
    input  logic                            rst_n,
    input  tx_dma_pkg::data_t               cq_data,
    input  logic                            cq_sof,
    input  logic                            cq_eof,
    input  logic                            cq_src_rdy,
    output logic                            cq_dst_rdy,
    output tx_dma_pkg::data_t               buf_data,
    output logic                            buf_last,
    output logic                            buf_valid,
    input  logic                            buf_ready,
    output tx_dma_pkg::chan_t               commit_chan,
    output tx_dma_pkg::pkt_size_t           commit_size,
    output tx_dma_pkg::hdr_meta_t           commit_meta,
    input  logic [tx_dma_pkg::CHANNELS-1:0] chan_en,
    output logic                            drop_pulse,
    output tx_dma_pkg::chan_t               drop_chan
);
    import tx_dma_pkg::*;

    parse_state_t state;
    parse_state_t state_nxt;

    chan_t     hdr_chan;
    pkt_size_t hdr_size;
    hdr_meta_t hdr_meta;
    logic      hdr_take;
    logic      hdr_en;
    logic      pass_done;
    logic      drop_done;

    // Header beat in IDLE, mask sampled right here
    assign hdr_take = (state == IDLE) && cq_src_rdy && cq_sof;
    assign hdr_en   = chan_en[cq_data[HDR_CHAN_MSB:HDR_CHAN_LSB]];

    // Payload goes straight to the buffer
    assign buf_data  = cq_data;
    assign buf_last  = cq_eof;
    assign buf_valid = (state == PASS) && cq_src_rdy;

    assign pass_done = buf_valid && buf_ready && cq_eof;
    assign drop_done = (state == DROP) && cq_src_rdy && cq_eof;

    always_comb begin
        case (state)
            PASS:    cq_dst_rdy = buf_ready;
            default: cq_dst_rdy = 1'b1;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (hdr_take) begin
                    state_nxt = hdr_en ? PASS : DROP;
                end
            end
            PASS: begin
                if (pass_done) begin
                    state_nxt = IDLE;
                end
            end
            DROP: begin
                if (drop_done) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Header fields kept for the whole packet
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            hdr_chan <= cq_data[HDR_CHAN_MSB:HDR_CHAN_LSB];
            hdr_size <= cq_data[HDR_SIZE_MSB:HDR_SIZE_LSB];
            hdr_meta <= cq_data[HDR_META_MSB:HDR_META_LSB];
        end
    end

    // Commit info is sampled by the buffer with the last word
    assign commit_chan = hdr_chan;
    assign commit_size = hdr_size;
    assign commit_meta = hdr_meta;

    // One pulse per discarded packet
    assign drop_pulse = drop_done;
    assign drop_chan  = hdr_chan;

endmodule

// File: hw/tx_dma_pkt_buffer.sv
// Store-and-forward packet buffer for the TX DMA
// Data FIFO plus metadata FIFO, drained into the framed user stream

`timescale 1ns/1ps

module tx_dma_pkt_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tx_dma_pkg::data_t     buf_data,
    input  logic                  buf_last,
    input  logic                  buf_valid,
    output logic                  buf_ready,
    input  tx_dma_pkg::chan_t     commit_chan,
    input  tx_dma_pkg::pkt_size_t commit_size,
    input  tx_dma_pkg::hdr_meta_t commit_meta,
    output tx_dma_pkg::data_t     usr_tx_data,
    output logic                  usr_tx_sof,
    output logic                  usr_tx_eof,
    output logic                  usr_tx_src_rdy,
    input  logic                  usr_tx_dst_rdy,
    output tx_dma_pkg::pkt_size_t usr_tx_pkt_size,
    output tx_dma_pkg::chan_t     usr_tx_chan,
    output tx_dma_pkg::hdr_meta_t usr_tx_meta,
    output logic                  sent_pulse,
    output tx_dma_pkg::chan_t     sent_chan
);
    import tx_dma_pkg::*;

    data_t     data_mem [BUF_DEPTH];
    chan_t     chan_mem [META_DEPTH];
    pkt_size_t size_mem [META_DEPTH];
    hdr_meta_t meta_mem [META_DEPTH];

    buf_ptr_t  data_wr_ptr;
    buf_ptr_t  data_rd_ptr;
    meta_ptr_t meta_wr_ptr;
    meta_ptr_t meta_rd_ptr;
    logic      data_full;
    logic      meta_full;
    logic      meta_empty;
    logic      data_wr;
    logic      meta_wr;

    // Packet currently read out
    logic      pkt_active;
    logic      pkt_first;
    pkt_size_t pkt_left;
    chan_t     cur_chan;
    pkt_size_t cur_size;
    hdr_meta_t cur_meta;
    logic      pkt_start;
    logic      slot_free;
    logic      beat_load;

    assign data_full  = (data_wr_ptr[BUF_AW] != data_rd_ptr[BUF_AW]) &&
                        (data_wr_ptr[BUF_AW-1:0] == data_rd_ptr[BUF_AW-1:0]);
    assign meta_full  = (meta_wr_ptr[META_AW] != meta_rd_ptr[META_AW]) &&
                        (meta_wr_ptr[META_AW-1:0] == meta_rd_ptr[META_AW-1:0]);
    assign meta_empty = (meta_wr_ptr == meta_rd_ptr);

    assign buf_ready = !data_full && !meta_full;
    assign data_wr   = buf_valid && buf_ready;
    assign meta_wr   = data_wr && buf_last;

    // Write side
    always_ff @(posedge clk) begin
        if (data_wr) begin
            data_mem[data_wr_ptr[BUF_AW-1:0]] <= buf_data;
        end
        if (meta_wr) begin
            chan_mem[meta_wr_ptr[META_AW-1:0]] <= commit_chan;
            size_mem[meta_wr_ptr[META_AW-1:0]] <= commit_size;
            meta_mem[meta_wr_ptr[META_AW-1:0]] <= commit_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_wr_ptr <= '0;
            meta_wr_ptr <= '0;
        end else begin
            if (data_wr) begin
                data_wr_ptr <= data_wr_ptr + 1'b1;
            end
            if (meta_wr) begin
                meta_wr_ptr <= meta_wr_ptr + 1'b1;
            end
        end
    end

    // Output slot can take a beat when empty or being consumed
    assign slot_free = !usr_tx_src_rdy || usr_tx_dst_rdy;
    assign pkt_start = !pkt_active && !meta_empty;
    assign beat_load = pkt_active && slot_free;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta_rd_ptr <= '0;
            data_rd_ptr <= '0;
            pkt_active  <= 1'b0;
            pkt_first   <= 1'b0;
            pkt_left    <= '0;
        end else if (pkt_start) begin
            meta_rd_ptr <= meta_rd_ptr + 1'b1;
            pkt_active  <= 1'b1;
            pkt_first   <= 1'b1;
            pkt_left    <= size_mem[meta_rd_ptr[META_AW-1:0]];
        end else if (beat_load) begin
            data_rd_ptr <= data_rd_ptr + 1'b1;
            pkt_first   <= 1'b0;
            pkt_left    <= pkt_left - 1'b1;
            if (pkt_left == pkt_size_t'(1)) begin
                pkt_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_start) begin
            cur_chan <= chan_mem[meta_rd_ptr[META_AW-1:0]];
            cur_size <= size_mem[meta_rd_ptr[META_AW-1:0]];
            cur_meta <= meta_mem[meta_rd_ptr[META_AW-1:0]];
        end
    end

    // Output framer, sof and eof drop with src_rdy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            usr_tx_src_rdy <= 1'b0;
            usr_tx_sof     <= 1'b0;
            usr_tx_eof     <= 1'b0;
        end else if (beat_load) begin
            usr_tx_src_rdy <= 1'b1;
            usr_tx_sof     <= pkt_first;
            usr_tx_eof     <= (pkt_left == pkt_size_t'(1));
        end else if (slot_free) begin
            usr_tx_src_rdy <= 1'b0;
            usr_tx_sof     <= 1'b0;
            usr_tx_eof     <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_load) begin
            usr_tx_data     <= data_mem[data_rd_ptr[BUF_AW-1:0]];
            usr_tx_pkt_size <= cur_size;
            usr_tx_chan     <= cur_chan;
            usr_tx_meta     <= cur_meta;
        end
    end

    assign sent_pulse = usr_tx_src_rdy && usr_tx_dst_rdy && usr_tx_eof;
    assign sent_chan  = usr_tx_chan;

endmodule

// File: hw/tx_dma_top.sv
// TX DMA lite top level
// Request parser feeding the packet buffer, with the MI register block

`timescale 1ns/1ps

module tx_dma_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // PCIe request stream
    input  tx_dma_pkg::data_t     cq_data,
    input  logic                  cq_sof,
    input  logic                  cq_eof,
    input  logic                  cq_src_rdy,
    output logic                  cq_dst_rdy,
    // User stream
    output tx_dma_pkg::data_t     usr_tx_data,
    output logic                  usr_tx_sof,
    output logic                  usr_tx_eof,
    output logic                  usr_tx_src_rdy,
    input  logic                  usr_tx_dst_rdy,
    output tx_dma_pkg::pkt_size_t usr_tx_pkt_size,
    output tx_dma_pkg::chan_t     usr_tx_chan,
    output tx_dma_pkg::hdr_meta_t usr_tx_meta,
    // Memory interface
    input  tx_dma_pkg::mi_addr_t  mi_addr,
    input  tx_dma_pkg::data_t     mi_dwr,
    input  logic                  mi_rd,
    input  logic                  mi_wr,
    output tx_dma_pkg::data_t     mi_drd,
    output logic                  mi_ardy,
    output logic                  mi_drdy
);
    import tx_dma_pkg::*;

    data_t                buf_data;
    logic                 buf_last;
    logic                 buf_valid;
    logic                 buf_ready;
    chan_t                commit_chan;
    pkt_size_t            commit_size;
    hdr_meta_t            commit_meta;
    logic [CHANNELS-1:0]  chan_en;
    logic                 drop_pulse;
    chan_t                drop_chan;
    logic                 sent_pulse;
    chan_t                sent_chan;

    tx_dma_cq_parser i_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .cq_data     (cq_data),
        .cq_sof      (cq_sof),
        .cq_eof      (cq_eof),
        .cq_src_rdy  (cq_src_rdy),
        .cq_dst_rdy  (cq_dst_rdy),
        .buf_data    (buf_data),
        .buf_last    (buf_last),
        .buf_valid   (buf_valid),
        .buf_ready   (buf_ready),
        .commit_chan (commit_chan),
        .commit_size (commit_size),
        .commit_meta (commit_meta),
        .chan_en     (chan_en),
        .drop_pulse  (drop_pulse),
        .drop_chan   (drop_chan)
    );

    tx_dma_pkt_buffer i_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .buf_data        (buf_data),
        .buf_last        (buf_last),
        .buf_valid       (buf_valid),
        .buf_ready       (buf_ready),
        .commit_chan     (commit_chan),
        .commit_size     (commit_size),
        .commit_meta     (commit_meta),
        .usr_tx_data     (usr_tx_data),
        .usr_tx_sof      (usr_tx_sof),
        .usr_tx_eof      (usr_tx_eof),
        .usr_tx_src_rdy  (usr_tx_src_rdy),
        .usr_tx_dst_rdy  (usr_tx_dst_rdy),
        .usr_tx_pkt_size (usr_tx_pkt_size),
        .usr_tx_chan     (usr_tx_chan),
        .usr_tx_meta     (usr_tx_meta),
        .sent_pulse      (sent_pulse),
        .sent_chan       (sent_chan)
    );

    tx_dma_regs i_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .mi_addr    (mi_addr),
        .mi_dwr     (mi_dwr),
        .mi_rd      (mi_rd),
        .mi_wr      (mi_wr),
        .mi_drd     (mi_drd),
        .mi_ardy    (mi_ardy),
        .mi_drdy    (mi_drdy),
        .sent_pulse (sent_pulse),
        .sent_chan  (sent_chan),
        .drop_pulse (drop_pulse),
        .drop_chan  (drop_chan),
        .chan_en    (chan_en)
    );

endmodule

// File: tests/tx_dma_clk_gen.sv
// Testbench clock source
// Free running clock with a 40 ns period

`timescale 1ns/1ps

module tx_dma_clk_gen (
    output logic clk
);
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

// File: tests/tx_dma_checker.sv
// TX DMA protocol checker
// Bound into the top level, watches the user stream and MI read timing

`timescale 1ns/1ps

module tx_dma_checker (
    input logic                  clk,
    input logic                  rst_n,
    input tx_dma_pkg::data_t     usr_tx_data,
    input logic                  usr_tx_sof,
    input logic                  usr_tx_eof,
    input logic                  usr_tx_src_rdy,
    input logic                  usr_tx_dst_rdy,
    input tx_dma_pkg::pkt_size_t usr_tx_pkt_size,
    input tx_dma_pkg::chan_t     usr_tx_chan,
    input tx_dma_pkg::hdr_meta_t usr_tx_meta,
    input logic                  mi_rd,
    input logic                  mi_drdy
);
    // Held beat must not move until it is taken
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        usr_tx_src_rdy && !usr_tx_dst_rdy |=> usr_tx_src_rdy && $stable(usr_tx_data) &&
            $stable(usr_tx_sof) && $stable(usr_tx_eof) && $stable(usr_tx_pkt_size) &&
            $stable(usr_tx_chan) && $stable(usr_tx_meta))
        else $error("User stream beat changed while stalled");

    // Framing bits only with a valid beat
    sof_with_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        usr_tx_sof |-> usr_tx_src_rdy)
        else $error("usr_tx_sof raised without usr_tx_src_rdy");

    eof_with_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        usr_tx_eof |-> usr_tx_src_rdy)
        else $error("usr_tx_eof raised without usr_tx_src_rdy");

    // Read data one cycle after the request, never otherwise
    drdy_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
        mi_rd |=> mi_drdy)
        else $error("mi_drdy missing one cycle after mi_rd");

    drdy_only_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
        mi_drdy |-> $past(mi_rd))
        else $error("mi_drdy without a read one cycle before");

    src_rdy_reset: assert property (@(posedge clk)
        !rst_n |=> !usr_tx_src_rdy)
        else $error("usr_tx_src_rdy high after reset");

endmodule

// File: tests/tx_dma_tb.sv
// TX DMA lite testbench
// Random packets with random gaps and output stalls, checked against a queue model

`timescale 1ns/1ps

module tx_dma_tb;
    import tx_dma_pkg::*;

    localparam int PKTS_PER_PHASE  = 24;
    localparam int NUM_PHASES      = 3;
    localparam int WATCHDOG_CYCLES = PKTS_PER_PHASE * NUM_PHASES * 200;

    logic      clk;
    logic      rst_n;
    data_t     cq_data;
    logic      cq_sof;
    logic      cq_eof;
    logic      cq_src_rdy;
    logic      cq_dst_rdy;
    data_t     usr_tx_data;
    logic      usr_tx_sof;
    logic      usr_tx_eof;
    logic      usr_tx_src_rdy;
    logic      usr_tx_dst_rdy = 1'b0;
    pkt_size_t usr_tx_pkt_size;
    chan_t     usr_tx_chan;
    hdr_meta_t usr_tx_meta;
    mi_addr_t  mi_addr;
    data_t     mi_dwr;
    logic      mi_rd;
    logic      mi_wr;
    data_t     mi_drd;
    logic      mi_ardy;
    logic      mi_drdy;

    // Model state, one entry per expected output beat {sof, eof, header, payload}
    logic [65:0]   exp_q[$];
    int            sent_model [CHANNELS];
    int            drop_model [CHANNELS];
    logic [3:0]    chan_mask;
    integer        seed = 32'h8455c8a0;
    int            rdy_pct = 70;
    logic          stalled = 1'b0;
    data_t         held_data;

    tx_dma_clk_gen i_clk_gen (.clk(clk));

    tx_dma_top i_dut (.*);

    bind tx_dma_top tx_dma_checker i_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .usr_tx_data     (usr_tx_data),
        .usr_tx_sof      (usr_tx_sof),
        .usr_tx_eof      (usr_tx_eof),
        .usr_tx_src_rdy  (usr_tx_src_rdy),
        .usr_tx_dst_rdy  (usr_tx_dst_rdy),
        .usr_tx_pkt_size (usr_tx_pkt_size),
        .usr_tx_chan     (usr_tx_chan),
        .usr_tx_meta     (usr_tx_meta),
        .mi_rd           (mi_rd),
        .mi_drdy         (mi_drdy)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s is 0x%0h, expected 0x%0h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic write_reg(input mi_addr_t addr, input data_t value);
        mi_addr = addr;
        mi_dwr  = value;
        mi_wr   = 1'b1;
        @(negedge clk);
        check_value("mi_ardy", mi_ardy, 1);
        mi_wr   = 1'b0;
    endtask

    // Read data must come exactly one cycle after the request
    task automatic read_expect(input mi_addr_t addr, input data_t exp, input string name);
        mi_addr = addr;
        mi_rd   = 1'b1;
        @(negedge clk);
        check_value("mi_ardy", mi_ardy, 1);
        mi_rd   = 1'b0;
        check_value("mi_drdy", mi_drdy, 1);
        check_value(name, mi_drd, exp);
        @(negedge clk);
        check_value("mi_drdy", mi_drdy, 0);
        check_value("mi_ardy", mi_ardy, 0);
    endtask

    // cq_dst_rdy follows only registered state, so it is settled at the falling edge
    task automatic put_beat(input data_t d, input logic sof, input logic eof);
        logic taken;
        cq_data    = d;
        cq_sof     = sof;
        cq_eof     = eof;
        cq_src_rdy = 1'b1;
        do begin
            taken = cq_dst_rdy;
            @(negedge clk);
        end while (!taken);
    endtask

    task automatic send_packet(input chan_t ch, input pkt_size_t sz, input hdr_meta_t meta);
        data_t hdr;
        data_t word;
        hdr = '0;
        hdr[HDR_CHAN_MSB:HDR_CHAN_LSB] = ch;
        hdr[HDR_SIZE_MSB:HDR_SIZE_LSB] = sz;
        hdr[HDR_META_MSB:HDR_META_LSB] = meta;
        if (chan_mask[ch]) begin
            sent_model[ch]++;
        end else begin
            drop_model[ch]++;
        end
        put_beat(hdr, 1'b1, 1'b0);
        for (int i = 0; i < sz; i++) begin
            word = $random(seed);
            if (chan_mask[ch]) begin
                exp_q.push_back({i == 0, i == sz - 1, hdr, word});
            end else begin
                // Discarded payload never waits for buffer space
                check_value("cq_dst_rdy (drop)", cq_dst_rdy, 1);
            end
            put_beat(word, 1'b0, i == sz - 1);
        end
        cq_src_rdy = 1'b0;
        cq_sof     = 1'b0;
        cq_eof     = 1'b0;
    endtask

    task automatic run_phase(input logic [3:0] mask, input int pct, input int max_gap);
        chan_t     ch;
        pkt_size_t sz;
        hdr_meta_t meta;
        write_reg(REG_CHAN_EN, data_t'(mask));
        chan_mask = mask;
        rdy_pct   = pct;
        repeat (PKTS_PER_PHASE) begin
            ch   = chan_t'($random(seed));
            sz   = pkt_size_t'(($random(seed) & 15) + 1);
            meta = hdr_meta_t'($random(seed));
            send_packet(ch, sz, meta);
            repeat ($unsigned($random(seed)) % (max_gap + 1)) @(negedge clk);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // Last beat is taken on the next rising edge
        @(negedge clk);
    endtask

    // Output side: pick dst_rdy, then check the beat that the next edge takes
    always @(negedge clk) begin
        logic [65:0] beat;
        data_t       hdr;
        if (stalled) begin
            check_value("usr_tx_src_rdy (stalled)", usr_tx_src_rdy, 1);
            check_value("usr_tx_data (stalled)", usr_tx_data, held_data);
        end
        usr_tx_dst_rdy = ($unsigned($random(seed)) % 100) < rdy_pct;
        stalled        = rst_n && usr_tx_src_rdy && !usr_tx_dst_rdy;
        held_data      = usr_tx_data;
        if (rst_n && usr_tx_src_rdy && usr_tx_dst_rdy) begin
            if (exp_q.size() == 0) begin
                report_failure("Output beat seen while no packet was expected");
            end else begin
                beat = exp_q.pop_front();
                hdr  = beat[63:32];
                check_value("usr_tx_sof", usr_tx_sof, beat[65]);
                check_value("usr_tx_eof", usr_tx_eof, beat[64]);
                check_value("usr_tx_data", usr_tx_data, beat[31:0]);
                if (beat[65]) begin
                    check_value("usr_tx_chan", usr_tx_chan, hdr[HDR_CHAN_MSB:HDR_CHAN_LSB]);
                    check_value("usr_tx_pkt_size", usr_tx_pkt_size,
                                hdr[HDR_SIZE_MSB:HDR_SIZE_LSB]);
                    check_value("usr_tx_meta", usr_tx_meta, hdr[HDR_META_MSB:HDR_META_LSB]);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("Timeout: run still busy after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        cq_data    = '0;
        cq_sof     = 1'b0;
        cq_eof     = 1'b0;
        cq_src_rdy = 1'b0;
        mi_addr    = '0;
        mi_dwr     = '0;
        mi_rd      = 1'b0;
        mi_wr      = 1'b0;
        chan_mask  = '0;
        rst_n      = 1'b0;
        for (int c = 0; c < CHANNELS; c++) begin
            sent_model[c] = 0;
            drop_model[c] = 0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_value("usr_tx_src_rdy", usr_tx_src_rdy, 0);
        check_value("cq_dst_rdy", cq_dst_rdy, 1);
        read_expect(REG_CHAN_EN, '0, "chan_en");
        for (int c = 0; c < CHANNELS; c++) begin
            read_expect(REG_SENT_BASE + mi_addr_t'(4 * c), '0, $sformatf("sent_cnt[%0d]", c));
            read_expect(REG_DROP_BASE + mi_addr_t'(4 * c), '0, $sformatf("drop_cnt[%0d]", c));
        end

        // All channels on, then a partial mask, then a burst into a mostly stalled output
        run_phase(4'hf, 70, 3);
        run_phase(4'b1010, 60, 3);
        run_phase(4'b0111, 8, 0);

        for (int c = 0; c < CHANNELS; c++) begin
            read_expect(REG_SENT_BASE + mi_addr_t'(4 * c), data_t'(sent_model[c]),
                        $sformatf("sent_cnt[%0d]", c));
            read_expect(REG_DROP_BASE + mi_addr_t'(4 * c), data_t'(drop_model[c]),
                        $sformatf("drop_cnt[%0d]", c));
        end
        read_expect(32'h0000_0040, '0, "unmapped register");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: tx_dma_lite.f
hw/tx_dma_pkg.sv
hw/tx_dma_regs.sv
hw/tx_dma_cq_parser.sv
hw/tx_dma_pkt_buffer.sv
hw/tx_dma_top.sv
tests/tx_dma_clk_gen.sv
tests/tx_dma_checker.sv
tests/tx_dma_tb.sv

// File: Makefile
# Verilator flow for the TX DMA lite testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f tx_dma_lite.f \
		--top-module tx_dma_tb -Mdir obj_dir
	./obj_dir/Vtx_dma_tb 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
